// File: Bender.yml
package:
  name: retire_trace

sources:
  # rtl, package first
  - files:
      - verilog/retire_trace_pkg.sv
      - verilog/retire_collector.sv
      - verilog/trace_fifo.sv
      - verilog/trace_emitter.sv
      - verilog/retire_trace.sv
  # testbench
  - target: test
    files:
      - verif/retire_trace_tb.sv

// File: list.f
verilog/retire_trace_pkg.sv
verilog/retire_collector.sv
verilog/trace_fifo.sv
verilog/trace_emitter.sv
verilog/retire_trace.sv
verif/retire_trace_tb.sv

// File: verif/retire_trace_tb.sv
/*
 * retire trace testbench
 * table and random commit streams checked against a queue model
 */
module retire_trace_tb;

  localparam int unsigned PERIOD     = 40;
  localparam int unsigned DRIVE_DLY  = 2;
  localparam int unsigned RESET_CYC  = 8;
  localparam int unsigned NUM_RANDOM = 200;
  localparam int unsigned MARGIN     = 64;

  localparam retire_trace_pkg::priv_lvl_t PRIV_U = retire_trace_pkg::PRIV_LVL_U;
  localparam retire_trace_pkg::priv_lvl_t PRIV_S = retire_trace_pkg::PRIV_LVL_S;
  localparam retire_trace_pkg::priv_lvl_t PRIV_M = retire_trace_pkg::PRIV_LVL_M;

  // one stimulus row, index 0 is commit port 0
  typedef struct packed {
    logic [1:0]                  ack;
    logic [1:0]                  exv;
    logic [1:0][31:0]            cause;
    logic [1:0][31:0]            tval;
    logic [1:0][63:0]            pc;
    retire_trace_pkg::priv_lvl_t priv;
    logic                        dbg;
  } row_t;

  logic                                                     clk_i;
  logic                                                     rst_ni;
  retire_trace_pkg::commit_entry_t [1:0]                    commit_instr_i;
  logic [1:0]                                               commit_ack_i;
  retire_trace_pkg::priv_lvl_t                              priv_lvl_i;
  logic                                                     debug_mode_i;
  retire_trace_pkg::trace_rec_t                             trace_o;
  logic                                                     trace_valid_o;
  logic                                                     overflow_o;

  row_t                         tbl[$];
  logic                         table_ready;
  logic [31:0]                  lcg_state;
  logic [31:0]                  model_cycle;
  retire_trace_pkg::trace_rec_t model_fifo[$];
  logic                         model_ovf;
  logic                         exp_valid;
  retire_trace_pkg::trace_rec_t exp_rec;

  retire_trace uut (
    .clk_i          ( clk_i          ),
    .rst_ni         ( rst_ni         ),
    .commit_instr_i ( commit_instr_i ),
    .commit_ack_i   ( commit_ack_i   ),
    .priv_lvl_i     ( priv_lvl_i     ),
    .debug_mode_i   ( debug_mode_i   ),
    .trace_o        ( trace_o        ),
    .trace_valid_o  ( trace_valid_o  ),
    .overflow_o     ( overflow_o     )
  );

  always #(PERIOD / 2) clk_i = ~clk_i;

  // --------------------------------------------------
  // helpers
  // --------------------------------------------------
  task automatic compare_value(input string name, input logic [131:0] got,
                               input logic [131:0] exp);
    if (got !== exp) begin
      $display("[FAIL] t=%0t %s got %0h expected %0h", $time, name, got, exp);
      $display("SOME TESTS FAILED");
      $fatal(1);
    end
  endtask

  function automatic logic [31:0] lcg_next();
    lcg_state = lcg_state * 32'd1664525 + 32'd1013904223;
    return lcg_state;
  endfunction

  function automatic row_t mk_row(input logic [1:0] ack, input logic [1:0] exv,
                                  input logic [31:0] c0, input logic [31:0] c1,
                                  input logic [31:0] t0, input logic [31:0] t1,
                                  input logic [63:0] pc0, input logic [63:0] pc1,
                                  input retire_trace_pkg::priv_lvl_t priv, input logic dbg);
    row_t r;
    r.ack      = ack;
    r.exv      = exv;
    r.cause[0] = c0;
    r.cause[1] = c1;
    r.tval[0]  = t0;
    r.tval[1]  = t1;
    r.pc[0]    = pc0;
    r.pc[1]    = pc1;
    r.priv     = priv;
    r.dbg      = dbg;
    return r;
  endfunction

  function automatic row_t rand_row();
    row_t        r;
    logic [31:0] x;
    x          = lcg_next();
    r.ack      = x[1:0];
    r.exv      = x[3:2];
    // debug mode roughly one row in sixteen
    r.dbg      = (x[7:4] == 4'd0);
    r.priv     = (x[9:8] == 2'd0) ? PRIV_U : ((x[9:8] == 2'd1) ? PRIV_S : PRIV_M);
    r.cause[0] = x[10] ? 32'd2 : {28'd0, x[14:11]};
    r.cause[1] = x[15] ? 32'd2 : {28'd0, x[19:16]};
    r.tval[0]  = lcg_next();
    r.tval[1]  = lcg_next();
    r.pc[0]    = {lcg_next(), lcg_next()};
    r.pc[1]    = {lcg_next(), lcg_next()};
    return r;
  endfunction

  // expected record for one acknowledged port
  function automatic retire_trace_pkg::trace_rec_t expect_rec(input row_t r, input int p,
                                                              input logic [31:0] cyc);
    retire_trace_pkg::trace_rec_t e;
    e       = '0;
    e.cycle = cyc;
    e.pc    = r.pc[p];
    if (r.dbg) begin
      e.mode = retire_trace_pkg::MODE_D;
    end else if (r.priv == PRIV_M) begin
      e.mode = retire_trace_pkg::MODE_M;
    end else if (r.priv == PRIV_S) begin
      e.mode = retire_trace_pkg::MODE_S;
    end else begin
      e.mode = retire_trace_pkg::MODE_U;
    end
    if (!r.exv[p] || r.dbg) begin
      e.kind          = retire_trace_pkg::REC_RETIRE;
      e.payload.instr = r.tval[p];
    end else if (r.cause[p] == 32'd2) begin
      e.kind          = retire_trace_pkg::REC_ILLEGAL;
      e.payload.instr = r.tval[p];
    end else begin
      e.kind          = retire_trace_pkg::REC_EXCEPT;
      e.payload.cause = r.cause[p];
    end
    return e;
  endfunction

  task automatic add_idle(input int n);
    repeat (n) tbl.push_back(mk_row(2'b00, 2'b00, 0, 0, 0, 0, 0, 0, PRIV_M, 1'b0));
  endtask

  task automatic fill_table();
    // single retire, then dual retire
    tbl.push_back(mk_row(2'b01, 2'b00, 0, 0, 32'h0000_0013, 0, 64'h8000_0000, 0, PRIV_M, 0));
    add_idle(2);
    tbl.push_back(mk_row(2'b11, 2'b00, 0, 0, 32'h0010_0093, 32'h0020_0113,
                         64'h8000_0004, 64'h8000_0008, PRIV_M, 0));
    add_idle(2);
    // illegal, other exception on port 1 only, exception under debug
    tbl.push_back(mk_row(2'b01, 2'b01, 32'd2, 0, 32'hdead_beef, 0, 64'h8000_0100, 0,
                         PRIV_S, 0));
    tbl.push_back(mk_row(2'b10, 2'b10, 0, 32'd5, 0, 32'h1234_5678, 0, 64'h8000_0200,
                         PRIV_U, 0));
    tbl.push_back(mk_row(2'b01, 2'b01, 32'd3, 0, 32'h0010_0073, 0, 64'h8000_0300, 0,
                         PRIV_M, 1));
    tbl.push_back(mk_row(2'b11, 2'b00, 0, 0, 32'h0000_0033, 32'h0000_0037,
                         64'h8000_0400, 64'h8000_0404, PRIV_U, 0));
    tbl.push_back(mk_row(2'b11, 2'b10, 0, 32'd2, 32'h0000_0063, 32'hffff_ffff,
                         64'h8000_0500, 64'h8000_0504, PRIV_S, 0));
    add_idle(4);
    // sustained dual commits, net +1 per cycle fills the queue
    for (int i = 0; i < 10; i++) begin
      tbl.push_back(mk_row(2'b11, 2'b00, 0, 0, 32'h1000 + 2 * i, 32'h1001 + 2 * i,
                           64'h9000_0000 + 8 * i, 64'h9000_0004 + 8 * i, PRIV_M, 0));
    end
    add_idle(12);
  endtask

  task automatic drive_row(input row_t r);
    commit_ack_i = r.ack;
    for (int p = 0; p < 2; p++) begin
      commit_instr_i[p].pc       = r.pc[p];
      commit_instr_i[p].ex_valid = r.exv[p];
      commit_instr_i[p].cause    = r.cause[p];
      commit_instr_i[p].tval     = r.tval[p];
    end
    priv_lvl_i   = r.priv;
    debug_mode_i = r.dbg;
  endtask

  // --------------------------------------------------
  // one commit cycle against the queue model
  // --------------------------------------------------
  task automatic run_cycle(input row_t r);
    retire_trace_pkg::trace_rec_t incoming[$];
    logic                         pop;
    drive_row(r);
    for (int p = 0; p < 2; p++) begin
      if (r.ack[p]) incoming.push_back(expect_rec(r, p, model_cycle));
    end
    pop = (model_fifo.size() != 0);
    @(posedge clk_i);
    #DRIVE_DLY;
    model_cycle = model_cycle + 1;
    exp_valid   = pop;
    if (pop) exp_rec = model_fifo.pop_front();
    // pop frees an entry first, then port order until full
    foreach (incoming[i]) begin
      if (model_fifo.size() < retire_trace_pkg::FIFO_DEPTH) begin
        model_fifo.push_back(incoming[i]);
      end else begin
        model_ovf = 1'b1;
      end
    end
    compare_value("trace_valid_o", trace_valid_o, exp_valid);
    if (exp_valid) begin
      compare_value("trace_o.cycle", trace_o.cycle, exp_rec.cycle);
      compare_value("trace_o.pc", trace_o.pc, exp_rec.pc);
      compare_value("trace_o.mode", trace_o.mode, exp_rec.mode);
      compare_value("trace_o.kind", trace_o.kind, exp_rec.kind);
      compare_value("trace_o.payload", trace_o.payload, exp_rec.payload);
    end
    compare_value("overflow_o", overflow_o, model_ovf);
  endtask

  // --------------------------------------------------
  // watchdog
  // --------------------------------------------------
  initial begin
    wait (table_ready);
    #((tbl.size() + NUM_RANDOM + RESET_CYC + MARGIN) * PERIOD);
    $display("timeout: the run did not finish within the expected number of cycles");
    $display("SOME TESTS FAILED");
    $fatal(1);
  end

  // --------------------------------------------------
  // main sequence
  // --------------------------------------------------
  initial begin
    clk_i          = 1'b0;
    rst_ni         = 1'b0;
    commit_instr_i = '0;
    commit_ack_i   = '0;
    priv_lvl_i     = PRIV_M;
    debug_mode_i   = 1'b0;
    lcg_state      = 32'h88a0;
    model_cycle    = '0;
    model_ovf      = 1'b0;
    exp_valid      = 1'b0;
    exp_rec        = '0;
    table_ready    = 1'b0;
    fill_table();
    table_ready = 1'b1;

    repeat (RESET_CYC) @(posedge clk_i);
    #DRIVE_DLY;
    rst_ni = 1'b1;
    compare_value("trace_valid_o", trace_valid_o, 1'b0);
    compare_value("overflow_o", overflow_o, 1'b0);

    foreach (tbl[i]) run_cycle(tbl[i]);
    // the burst is deeper than the queue
    compare_value("overflow_o", overflow_o, 1'b1);

    // random stream, then drain until the model holds nothing
    repeat (NUM_RANDOM) run_cycle(rand_row());
    while (model_fifo.size() != 0) begin
      run_cycle(mk_row(2'b00, 2'b00, 0, 0, 0, 0, 0, 0, PRIV_M, 1'b0));
    end
    // one quiet cycle, no stray record may follow
    run_cycle(mk_row(2'b00, 2'b00, 0, 0, 0, 0, 0, 0, PRIV_M, 1'b0));

    $display("ALL TESTS PASSED");
    $finish;
  end

endmodule

// File: verilog/retire_collector.sv
/*
 * retire collector
 * turns acknowledged commit ports into trace records, classifies them,
 * stamps mode and cycle count and packs valid records into slot order
 */
module retire_collector (
  input  logic                                                        clk_i,
  input  logic                                                        rst_ni,
  input  retire_trace_pkg::commit_entry_t [retire_trace_pkg::NR_COMMIT_PORTS-1:0] commit_instr_i,
  input  logic [retire_trace_pkg::NR_COMMIT_PORTS-1:0]                commit_ack_i,
  input  retire_trace_pkg::priv_lvl_t                                 priv_lvl_i,
  input  logic                                                        debug_mode_i,
  output retire_trace_pkg::trace_rec_t [retire_trace_pkg::NR_COMMIT_PORTS-1:0] rec_o,
  output logic [retire_trace_pkg::NR_COMMIT_PORTS-1:0]                rec_valid_o
);

  localparam int unsigned NrPorts = retire_trace_pkg::NR_COMMIT_PORTS;

  logic [retire_trace_pkg::CYCLE_W-1:0]         cycle_q;
  retire_trace_pkg::mode_e                      mode;
  retire_trace_pkg::trace_rec_t [NrPorts-1:0]   port_rec;

  // --------------------------------------------------
  // cycle counter
  // --------------------------------------------------
  // counts edges since reset release
  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      cycle_q <= '0;
    end else begin
      cycle_q <= cycle_q + 1'b1;
    end
  end

  // --------------------------------------------------
  // mode letter
  // --------------------------------------------------
  always_comb begin
    if (debug_mode_i) begin
      mode = retire_trace_pkg::MODE_D;
    end else begin
      case (priv_lvl_i)
        retire_trace_pkg::PRIV_LVL_M: mode = retire_trace_pkg::MODE_M;
        retire_trace_pkg::PRIV_LVL_S: mode = retire_trace_pkg::MODE_S;
        default:                      mode = retire_trace_pkg::MODE_U;
      endcase
    end
  end

  // --------------------------------------------------
  // per port classification
  // --------------------------------------------------
  always_comb begin
    for (int p = 0; p < NrPorts; p++) begin
      port_rec[p].cycle = cycle_q;
      port_rec[p].pc    = commit_instr_i[p].pc;
      port_rec[p].mode  = mode;
      // in debug mode even a trapping entry is traced as retired
      if (!commit_instr_i[p].ex_valid || debug_mode_i) begin
        port_rec[p].kind          = retire_trace_pkg::REC_RETIRE;
        port_rec[p].payload.instr = commit_instr_i[p].tval;
      end else if (commit_instr_i[p].cause == retire_trace_pkg::CAUSE_ILLEGAL_INSTR) begin
        // tval carries the offending instruction word
        port_rec[p].kind          = retire_trace_pkg::REC_ILLEGAL;
        port_rec[p].payload.instr = commit_instr_i[p].tval;
      end else begin
        port_rec[p].kind          = retire_trace_pkg::REC_EXCEPT;
        port_rec[p].payload.cause = commit_instr_i[p].cause;
      end
    end
  end

  // --------------------------------------------------
  // compaction
  // --------------------------------------------------
  // acknowledged ports fill slots from 0 upwards, port order kept
  always_comb begin
    int unsigned slot;
    slot        = 0;
    rec_o       = '0;
    rec_valid_o = '0;
    for (int p = 0; p < NrPorts; p++) begin
      if (commit_ack_i[p]) begin
        rec_o[slot]       = port_rec[p];
        rec_valid_o[slot] = 1'b1;
        slot++;
      end
    end
  end

endmodule

// File: verilog/retire_trace.sv
/*
 * retire trace top
 * commit ports in, one trace record per cycle out;
 * collector feeds a bounded queue which the emitter drains
 */
module retire_trace (
  input  logic                                                        clk_i,
  input  logic                                                        rst_ni,
  input  retire_trace_pkg::commit_entry_t [retire_trace_pkg::NR_COMMIT_PORTS-1:0] commit_instr_i,
  input  logic [retire_trace_pkg::NR_COMMIT_PORTS-1:0]                commit_ack_i,
  input  retire_trace_pkg::priv_lvl_t                                 priv_lvl_i,
  input  logic                                                        debug_mode_i,
  output retire_trace_pkg::trace_rec_t                                trace_o,
  output logic                                                        trace_valid_o,
  output logic                                                        overflow_o
);

  // collector to queue
  retire_trace_pkg::trace_rec_t [retire_trace_pkg::NR_COMMIT_PORTS-1:0] rec;
  logic [retire_trace_pkg::NR_COMMIT_PORTS-1:0]                         rec_valid;

  // queue to emitter
  retire_trace_pkg::trace_rec_t head;
  logic                         empty;
  logic                         pop;

  // --------------------------------------------------
  // collector
  // --------------------------------------------------
  retire_collector i_collector (
    .clk_i          ( clk_i          ),
    .rst_ni         ( rst_ni         ),
    .commit_instr_i ( commit_instr_i ),
    .commit_ack_i   ( commit_ack_i   ),
    .priv_lvl_i     ( priv_lvl_i     ),
    .debug_mode_i   ( debug_mode_i   ),
    .rec_o          ( rec            ),
    .rec_valid_o    ( rec_valid      )
  );

  // --------------------------------------------------
  // queue
  // --------------------------------------------------
  trace_fifo i_fifo (
    .clk_i       ( clk_i      ),
    .rst_ni      ( rst_ni     ),
    .rec_i       ( rec        ),
    .rec_valid_i ( rec_valid  ),
    .pop_i       ( pop        ),
    .head_o      ( head       ),
    .empty_o     ( empty      ),
    .overflow_o  ( overflow_o )
  );

  // --------------------------------------------------
  // emitter
  // --------------------------------------------------
  trace_emitter i_emitter (
    .clk_i         ( clk_i         ),
    .rst_ni        ( rst_ni        ),
    .head_i        ( head          ),
    .empty_i       ( empty         ),
    .pop_o         ( pop           ),
    .trace_o       ( trace_o       ),
    .trace_valid_o ( trace_valid_o )
  );

endmodule

// File: verilog/retire_trace_pkg.sv
/*
 * retire trace package
 * widths, commit entry layout, record kinds, mode codes and the
 * trace record shared by the collector, queue and emitter
 */
package retire_trace_pkg;

  // --------------------------------------------------
  // sizes
  // --------------------------------------------------
  localparam int unsigned NR_COMMIT_PORTS = 2;
  localparam int unsigned XLEN            = 64;
  localparam int unsigned INSTR_W         = 32;
  localparam int unsigned CAUSE_W         = 32;
  localparam int unsigned CYCLE_W         = 32;

  // queue geometry, depth must stay a power of two
  localparam int unsigned FIFO_DEPTH = 8;
  localparam int unsigned FIFO_PTR_W = $clog2(FIFO_DEPTH);
  localparam int unsigned FIFO_CNT_W = $clog2(FIFO_DEPTH + 1);

  // exception cause for an illegal instruction
  localparam logic [CAUSE_W-1:0] CAUSE_ILLEGAL_INSTR = 32'd2;

  // --------------------------------------------------
  // encodings
  // --------------------------------------------------
  // privilege level as seen by the core
  typedef enum logic [1:0] {
    PRIV_LVL_U = 2'd0,
    PRIV_LVL_S = 2'd1,
    PRIV_LVL_M = 2'd3
  } priv_lvl_t;

  // mode letter written into each record
  typedef enum logic [1:0] {
    MODE_U = 2'd0,
    MODE_S = 2'd1,
    MODE_M = 2'd2,
    MODE_D = 2'd3
  } mode_e;

  // what a record describes
  typedef enum logic [1:0] {
    REC_RETIRE  = 2'd0,
    REC_ILLEGAL = 2'd1,
    REC_EXCEPT  = 2'd2
  } rec_kind_e;

  // --------------------------------------------------
  // records
  // --------------------------------------------------
  // one commit port entry, 129 bits
  typedef struct packed {
    logic [XLEN-1:0]    pc;
    logic               ex_valid;
    logic [CAUSE_W-1:0] cause;
    logic [INSTR_W-1:0] tval;
  } commit_entry_t;

  // payload word, kind decides the reading
  typedef union packed {
    logic [INSTR_W-1:0] instr;
    logic [CAUSE_W-1:0] cause;
  } trace_payload_u;

  // one trace record, 132 bits
  typedef struct packed {
    logic [CYCLE_W-1:0] cycle;
    logic [XLEN-1:0]    pc;
    mode_e              mode;
    rec_kind_e          kind;
    trace_payload_u     payload;
  } trace_rec_t;

endpackage

// File: verilog/trace_emitter.sv
/*
 * trace emitter
 * drains the queue one record per cycle onto a registered trace port
 * with a single-cycle valid strobe
 */
module trace_emitter (
  input  logic                          clk_i,
  input  logic                          rst_ni,
  input  retire_trace_pkg::trace_rec_t  head_i,
  input  logic                          empty_i,
  output logic                          pop_o,
  output retire_trace_pkg::trace_rec_t  trace_o,
  output logic                          trace_valid_o
);

  retire_trace_pkg::trace_rec_t trace_q;
  logic                         trace_valid_q;

  // --------------------------------------------------
  // pop request
  // --------------------------------------------------
  // no ready on the trace side, so any queued head leaves at once
  assign pop_o = ~empty_i;

  // --------------------------------------------------
  // output register
  // --------------------------------------------------
  // strobe follows the pop by one edge
  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      trace_valid_q <= 1'b0;
    end else begin
      trace_valid_q <= pop_o;
    end
  end

  // record only loads on a pop, holds otherwise
  always_ff @(posedge clk_i) begin
    if (pop_o) begin
      trace_q <= head_i;
    end
  end

  assign trace_o       = trace_q;
  assign trace_valid_o = trace_valid_q;

endmodule

// File: verilog/trace_fifo.sv
/*
 * trace fifo
 * bounded in-order queue of trace records, up to two writes and one
 * read per cycle; records that do not fit are dropped and flagged
 */
module trace_fifo (
  input  logic                                                        clk_i,
  input  logic                                                        rst_ni,
  input  retire_trace_pkg::trace_rec_t [retire_trace_pkg::NR_COMMIT_PORTS-1:0] rec_i,
  input  logic [retire_trace_pkg::NR_COMMIT_PORTS-1:0]                rec_valid_i,
  input  logic                                                        pop_i,
  output retire_trace_pkg::trace_rec_t                                head_o,
  output logic                                                        empty_o,
  output logic                                                        overflow_o
);

  localparam int unsigned NrSlots = retire_trace_pkg::NR_COMMIT_PORTS;
  localparam int unsigned PtrW    = retire_trace_pkg::FIFO_PTR_W;
  localparam int unsigned CntW    = retire_trace_pkg::FIFO_CNT_W;

  retire_trace_pkg::trace_rec_t mem_q [retire_trace_pkg::FIFO_DEPTH];

  logic [PtrW-1:0]                rd_ptr_q;
  logic [PtrW-1:0]                wr_ptr_q;
  logic [CntW-1:0]                count_q;
  logic                           overflow_q;

  logic                           pop_en;
  logic [CntW-1:0]                space;
  logic [CntW-1:0]                n_wr;
  logic                           drop;
  logic [NrSlots-1:0]             wr_en;
  logic [NrSlots-1:0][PtrW-1:0]   wr_addr;

  // --------------------------------------------------
  // write admission
  // --------------------------------------------------
  always_comb begin
    pop_en = pop_i && (count_q != '0);
    // a pop this cycle frees its entry for the incoming write
    space  = CntW'(retire_trace_pkg::FIFO_DEPTH) - count_q + CntW'(pop_en);
    n_wr   = '0;
    drop   = 1'b0;
    wr_en   = '0;
    wr_addr = '0;
    for (int k = 0; k < NrSlots; k++) begin
      if (rec_valid_i[k]) begin
        if (n_wr < space) begin
          wr_en[k]   = 1'b1;
          wr_addr[k] = wr_ptr_q + n_wr[PtrW-1:0];
          n_wr       = n_wr + 1'b1;
        end else begin
          drop = 1'b1;
        end
      end
    end
  end

  // --------------------------------------------------
  // storage
  // --------------------------------------------------
  always_ff @(posedge clk_i) begin
    for (int k = 0; k < NrSlots; k++) begin
      if (wr_en[k]) begin
        mem_q[wr_addr[k]] <= rec_i[k];
      end
    end
  end

  // pointers wrap on their own, depth is a power of two
  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      rd_ptr_q   <= '0;
      wr_ptr_q   <= '0;
      count_q    <= '0;
      overflow_q <= 1'b0;
    end else begin
      rd_ptr_q <= rd_ptr_q + PtrW'(pop_en);
      wr_ptr_q <= wr_ptr_q + n_wr[PtrW-1:0];
      count_q  <= count_q + n_wr - CntW'(pop_en);
      // sticky until reset
      if (drop) begin
        overflow_q <= 1'b1;
      end
    end
  end

  assign head_o     = mem_q[rd_ptr_q];
  assign empty_o    = (count_q == '0);
  assign overflow_o = overflow_q;

endmodule
